/* checker_pkg.sv */
package checker_pkg;

  // Data path widths
  localparam int WORD_W = 64;
  localparam int CSR_DW = 32;
  localparam int CSR_AW = 14;

  // Memory geometry
  localparam int MEM_AW = 8;
  localparam int MEM_DEPTH = 1 << MEM_AW;
  // Page index width, 16 pages of 16 words
  localparam int PAGE_AW = 4;
  // Word offset inside a page
  localparam int PAGE_OFS_W = MEM_AW - PAGE_AW;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [CSR_DW-1:0] csr_data_t;
  typedef logic [CSR_AW-1:0] csr_addr_t;
  typedef logic [MEM_AW-1:0] mem_addr_t;
  typedef logic [PAGE_AW-1:0] page_t;

  // Check modes, encoded as in CTRL bits 2:1
  typedef enum logic [1:0] {
    MODE_SINGLE = 2'd0,
    MODE_AUTO   = 2'd1,
    MODE_READ   = 2'd2,
    MODE_DUMMY  = 2'd3
  } checker_mode_t;

  // Engine FSM
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_ISSUE = 2'd1,
    ST_DRAIN = 2'd2,
    ST_END   = 2'd3
  } engine_state_t;

  // CSR word offsets, decoded from csr_a bits 2:0
  localparam logic [2:0] CSR_ADDR_LO   = 3'd0;
  localparam logic [2:0] CSR_ADDR_HI   = 3'd1;
  // STAT bit 0 done, bit 1 error
  localparam logic [2:0] CSR_STAT      = 3'd2;
  // CTRL bit 0 irq enable, bits 2:1 mode, bit 3 start
  localparam logic [2:0] CSR_CTRL      = 3'd3;
  localparam logic [2:0] CSR_RESULT_LO = 3'd4;
  localparam logic [2:0] CSR_RESULT_HI = 3'd5;

  // Window select, compared with csr_a bits 13:10
  localparam logic [3:0] CHECKER_CSR_BASE = 4'h0;

endpackage

/* checker_mem_if.sv */
`timescale 1ns/1ps

interface checker_mem_if import checker_pkg::*; ();

  // Request side, one strobe per word
  logic      rd;
  mem_addr_t rd_addr;

  // Response side, one cycle after rd
  logic      rvalid;
  word_t     rdata;
  // Address of the returning word
  mem_addr_t raddr;

  // Engine end
  modport requester (
    output rd, rd_addr,
    input  rvalid, rdata, raddr
  );

  // Memory end
  modport responder (
    input  rd, rd_addr,
    output rvalid, rdata, raddr
  );

endinterface

/* checker_ctlif.sv */
`timescale 1ns/1ps

module checker_ctlif import checker_pkg::*; #(
  parameter logic [3:0] csr_addr = 4'h0
) (
  input  logic          sys_clk,
  input  logic          sys_rst,

  // Host CSR port
  input  csr_addr_t     csr_a,
  input  logic          csr_we,
  input  csr_data_t     csr_di,
  output csr_data_t     csr_do,

  // Engine control, held while start is high
  output checker_mode_t cmode,
  output logic          cstart,
  output word_t         caddr,

  // Engine completion
  input  logic          cend,
  input  logic          cerr,
  input  word_t         cresult,

  output logic          irq
);

  logic  csr_selected;
  logic  busy;
  logic  event_done;
  logic  event_error;
  logic  irq_en;
  word_t result_q;

  // Window hit on the upper address bits
  assign csr_selected = csr_a[13:10] == csr_addr;

  // Start stays high from the start write until cend or abort
  assign busy = cstart;

  // Either event raises the line when enabled
  assign irq = irq_en & (event_done | event_error);

  // Registered read data
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      csr_do <= '0;
    end else begin
      csr_do <= '0;
      if (csr_selected) begin
        case (csr_a[2:0])
          CSR_ADDR_LO: csr_do <= caddr[31:0];
          CSR_ADDR_HI: csr_do <= caddr[63:32];
          CSR_STAT: csr_do <= {30'd0, event_error, event_done};
          CSR_CTRL: csr_do <= {28'd0, cstart, cmode, irq_en};
          CSR_RESULT_LO: csr_do <= result_q[31:0];
          CSR_RESULT_HI: csr_do <= result_q[63:32];
          default: csr_do <= '0;
        endcase
      end
    end
  end

  // Register writes and engine events
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      caddr <= '0;
      cmode <= MODE_SINGLE;
      irq_en <= 1'b0;
      cstart <= 1'b0;
      event_done <= 1'b0;
      event_error <= 1'b0;
      result_q <= '0;
    end else begin
      if (csr_selected && csr_we) begin
        case (csr_a[2:0])
          CSR_ADDR_LO: begin
            if (!busy) begin
              caddr[31:0] <= csr_di;
            end
          end
          CSR_ADDR_HI: begin
            if (!busy) begin
              caddr[63:32] <= csr_di;
            end
          end
          CSR_STAT: begin
            // Write one to clear
            if (!busy) begin
              if (csr_di[0]) begin
                event_done <= 1'b0;
              end
              if (csr_di[1]) begin
                event_error <= 1'b0;
              end
            end
          end
          CSR_CTRL: begin
            if (!busy) begin
              irq_en <= csr_di[0];
              cmode <= checker_mode_t'(csr_di[2:1]);
            end
            // Always writable, 0 aborts a run
            cstart <= csr_di[3];
          end
          default: begin
          end
        endcase
      end
      // End strobe wins over a same-cycle start write
      if (cend) begin
        cstart <= 1'b0;
        event_done <= 1'b1;
        if (cerr) begin
          event_error <= 1'b1;
        end
        result_q <= cresult;
      end
    end
  end

  // End strobe only closes a run that was started
  assert property (@(posedge sys_clk) disable iff (sys_rst)
    cend |-> $past(cstart));

endmodule

/* checker_engine.sv */
`timescale 1ns/1ps

module checker_engine import checker_pkg::*; (
  input  logic          sys_clk,
  input  logic          sys_rst,

  // Control block side
  input  checker_mode_t cmode,
  input  logic          cstart,
  input  word_t         caddr,
  output logic          cend,
  output logic          cerr,
  output word_t         cresult,

  // Memory read port
  checker_mem_if.requester mem
);

  engine_state_t state;
  page_t         page;
  mem_addr_t     issue_addr;
  mem_addr_t     first_addr;
  mem_addr_t     last_addr;
  logic          check_en;
  logic          word_bad;
  logic          resp_live;
  logic          bad_hit;
  logic          err_q;
  word_t         result_q;

  // Page holding the requested address
  assign page = caddr[MEM_AW-1:PAGE_OFS_W];

  // Scan range per mode
  always_comb begin
    case (cmode)
      MODE_SINGLE: begin
        first_addr = {page, {PAGE_OFS_W{1'b0}}};
        last_addr = {page, {PAGE_OFS_W{1'b1}}};
      end
      MODE_AUTO: begin
        first_addr = '0;
        last_addr = '1;
      end
      default: begin
        // Read fetches one word, dummy never issues
        first_addr = caddr[MEM_AW-1:0];
        last_addr = caddr[MEM_AW-1:0];
      end
    endcase
  end

  // Only the scanning modes apply the word rule
  assign check_en = (cmode == MODE_SINGLE) || (cmode == MODE_AUTO);

  // Good word has upper half equal to inverted lower half
  assign word_bad = mem.rdata[63:32] != ~mem.rdata[31:0];

  // Responses count only during an active run
  assign resp_live = mem.rvalid && ((state == ST_ISSUE) || (state == ST_DRAIN));

  // First failing word of this run
  assign bad_hit = resp_live && check_en && word_bad && !err_q;

  // One read per cycle while issuing
  assign mem.rd = state == ST_ISSUE;
  assign mem.rd_addr = issue_addr;

  assign cend = state == ST_END;
  assign cerr = err_q;
  assign cresult = result_q;

  // FSM and error flag
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      state <= ST_IDLE;
      err_q <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (cstart) begin
            err_q <= 1'b0;
            state <= (cmode == MODE_DUMMY) ? ST_END : ST_ISSUE;
          end
        end
        ST_ISSUE: begin
          if (!cstart) begin
            // Abort, no end strobe
            state <= ST_IDLE;
          end else if (bad_hit || (issue_addr == last_addr)) begin
            state <= ST_DRAIN;
          end
        end
        ST_DRAIN: begin
          // Fixed one-cycle latency, last read returns here
          if (!cstart) begin
            state <= ST_IDLE;
          end else begin
            state <= ST_END;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
      if (bad_hit) begin
        err_q <= 1'b1;
      end
    end
  end

  // Read pointer and result value
  always_ff @(posedge sys_clk) begin
    if ((state == ST_IDLE) && cstart) begin
      issue_addr <= first_addr;
      result_q <= '0;
    end else begin
      if (state == ST_ISSUE) begin
        issue_addr <= issue_addr + 1'b1;
      end
      if (bad_hit) begin
        // Report the failing word address
        result_q <= word_t'(mem.raddr);
      end else if (resp_live && (cmode == MODE_READ)) begin
        result_q <= mem.rdata;
      end
    end
  end

  // Reads stay inside the scan range of the mode
  assert property (@(posedge sys_clk) disable iff (sys_rst)
    mem.rd |-> (mem.rd_addr >= first_addr) && (mem.rd_addr <= last_addr));

endmodule

/* checker_mem.sv */
`timescale 1ns/1ps

module checker_mem import checker_pkg::*; (
  input  logic      sys_clk,

  // Host preload port
  input  logic      load_we,
  input  mem_addr_t load_addr,
  input  word_t     load_data,

  // Engine read port
  checker_mem_if.responder mem
);

  // Word storage
  word_t mem_array [MEM_DEPTH];

  // Host writes
  always_ff @(posedge sys_clk) begin
    if (load_we) begin
      mem_array[load_addr] <= load_data;
    end
  end

  // Synchronous read, address echoed with the data
  always_ff @(posedge sys_clk) begin
    if (mem.rd) begin
      mem.rdata <= mem_array[mem.rd_addr];
      mem.raddr <= mem.rd_addr;
    end
  end

  // Response strobe trails the request by one cycle
  always_ff @(posedge sys_clk) begin
    mem.rvalid <= mem.rd;
  end

  // Every returned word was preloaded by the host
  assert property (@(posedge sys_clk) mem.rvalid |-> !$isunknown(mem.rdata));

endmodule

/* checker_top.sv */
`timescale 1ns/1ps

module checker_top import checker_pkg::*; (
  input  logic      sys_clk,
  input  logic      sys_rst,

  // CSR bus
  input  csr_addr_t csr_a,
  input  logic      csr_we,
  input  csr_data_t csr_di,
  output csr_data_t csr_do,
  output logic      irq,

  // Memory preload
  input  logic      load_we,
  input  mem_addr_t load_addr,
  input  word_t     load_data
);

  // Control to engine
  checker_mode_t cmode;
  logic          cstart;
  word_t         caddr;

  // Engine to control
  logic          cend;
  logic          cerr;
  word_t         cresult;

  // Engine to memory
  checker_mem_if mem_if ();

  checker_ctlif #(
    .csr_addr (CHECKER_CSR_BASE)
  ) u_ctlif (
    .sys_clk (sys_clk),
    .sys_rst (sys_rst),
    .csr_a   (csr_a),
    .csr_we  (csr_we),
    .csr_di  (csr_di),
    .csr_do  (csr_do),
    .cmode   (cmode),
    .cstart  (cstart),
    .caddr   (caddr),
    .cend    (cend),
    .cerr    (cerr),
    .cresult (cresult),
    .irq     (irq)
  );

  checker_engine u_engine (
    .sys_clk (sys_clk),
    .sys_rst (sys_rst),
    .cmode   (cmode),
    .cstart  (cstart),
    .caddr   (caddr),
    .cend    (cend),
    .cerr    (cerr),
    .cresult (cresult),
    .mem     (mem_if)
  );

  checker_mem u_mem (
    .sys_clk   (sys_clk),
    .load_we   (load_we),
    .load_addr (load_addr),
    .load_data (load_data),
    .mem       (mem_if)
  );

endmodule

/* tb_checker.sv */
`timescale 1ns/1ps

module tb_checker import checker_pkg::*; ();

  logic          sys_clk;
  logic          sys_rst;
  csr_addr_t     csr_a;
  logic          csr_we;
  csr_data_t     csr_di;
  csr_data_t     csr_do;
  logic          irq;
  logic          load_we;
  mem_addr_t     load_addr;
  word_t         load_data;

  // Reference copy of the memory
  word_t         mem_model [MEM_DEPTH];
  // CSR model
  word_t         model_addr;
  checker_mode_t model_mode;
  logic          model_irq_en;
  logic [31:0]   rng_state;

  checker_top u_dut (
    .sys_clk   (sys_clk),
    .sys_rst   (sys_rst),
    .csr_a     (csr_a),
    .csr_we    (csr_we),
    .csr_di    (csr_di),
    .csr_do    (csr_do),
    .irq       (irq),
    .load_we   (load_we),
    .load_addr (load_addr),
    .load_data (load_data)
  );

  // 100 ns clock
  always #50 sys_clk = ~sys_clk;

  // xorshift32
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  // Upper half is the inverse of the lower half
  function automatic word_t good_word(input logic [31:0] lo);
    return {~lo, lo};
  endfunction

  function automatic logic word_is_good(input word_t w);
    return w[63:32] == ~w[31:0];
  endfunction

  // Lowest bad address in a range, -1 when all good
  function automatic int first_bad_addr(input int first, input int last);
    for (int a = first; a <= last; a++) begin
      if (!word_is_good(mem_model[a])) begin
        return a;
      end
    end
    return -1;
  endfunction

  function automatic csr_addr_t csr_at(input logic [2:0] ofs);
    return {CHECKER_CSR_BASE, 7'd0, ofs};
  endfunction

  // CTRL image from the model
  function automatic csr_data_t ctrl_value(input logic start);
    return {28'd0, start, model_mode, model_irq_en};
  endfunction

  task automatic stop_on_failure();
    $display("RESULT: FAIL");
    $fatal(1, "Stopped at the first failed check");
  endtask

  task automatic check_csr(input csr_data_t got, input csr_data_t exp, input string msg);
    if (got !== exp) begin
      $display("Error at %0t: %s, got %h, expected %h", $time, msg, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string msg);
    if (got !== exp) begin
      $display("Error at %0t: %s, got %h, expected %h", $time, msg, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_irq(input bit exp, input string msg);
    if (irq !== exp) begin
      $display("Error at %0t: %s, irq is %b, expected %b", $time, msg, irq, exp);
      stop_on_failure();
    end
  endtask

  // All tasks start and end 1 ns after a rising edge
  task automatic csr_write(input logic [2:0] ofs, input csr_data_t data);
    csr_a = csr_at(ofs);
    csr_di = data;
    csr_we = 1'b1;
    @(posedge sys_clk);
    #1;
    csr_we = 1'b0;
    csr_di = '0;
  endtask

  // Read data is registered, valid one edge later
  task automatic csr_read(input csr_addr_t addr, output csr_data_t data);
    csr_a = addr;
    csr_we = 1'b0;
    @(posedge sys_clk);
    #1;
    data = csr_do;
  endtask

  task automatic expect_csr(input logic [2:0] ofs, input csr_data_t exp, input string msg);
    csr_data_t val;
    csr_read(csr_at(ofs), val);
    check_csr(val, exp, msg);
  endtask

  // Preload one word, keeping the model in step
  task automatic load_word(input mem_addr_t addr, input word_t data);
    mem_model[addr] = data;
    load_addr = addr;
    load_data = data;
    load_we = 1'b1;
    @(posedge sys_clk);
    #1;
    load_we = 1'b0;
  endtask

  task automatic fill_good_memory();
    for (int a = 0; a < MEM_DEPTH; a++) begin
      load_word(mem_addr_t'(a), good_word(next_rand()));
    end
  endtask

  task automatic wait_for_irq(input int max_cycles);
    int n;
    n = 0;
    while (!irq && n < max_cycles) begin
      @(posedge sys_clk);
      #1;
      n++;
    end
    if (!irq) begin
      $display("Timeout: irq did not rise within %0d cycles", max_cycles);
      stop_on_failure();
    end
  endtask

  // Irq must stay low for the whole window
  task automatic expect_no_irq(input int cycles);
    for (int n = 0; n < cycles; n++) begin
      @(posedge sys_clk);
      #1;
      if (irq) begin
        $display("Irq rose %0d cycles after the run was aborted", n);
        stop_on_failure();
      end
    end
  endtask

  // Full run with irq enabled, then status and result checks
  task automatic run_mode(input checker_mode_t mode, input word_t addr, input logic exp_err,
                          input logic check_result, input word_t exp_result);
    csr_data_t lo;
    csr_data_t hi;
    csr_write(CSR_STAT, 32'h3);
    csr_write(CSR_ADDR_LO, addr[31:0]);
    csr_write(CSR_ADDR_HI, addr[63:32]);
    model_addr = addr;
    model_mode = mode;
    model_irq_en = 1'b1;
    csr_write(CSR_CTRL, ctrl_value(1'b1));
    wait_for_irq(1000);
    expect_csr(CSR_STAT, {30'd0, exp_err, 1'b1}, "STAT after run");
    // Start drops with the end strobe
    expect_csr(CSR_CTRL, ctrl_value(1'b0), "CTRL after run");
    if (check_result) begin
      csr_read(csr_at(CSR_RESULT_LO), lo);
      csr_read(csr_at(CSR_RESULT_HI), hi);
      check_word({hi, lo}, exp_result, "result");
    end
  endtask

  initial begin
    word_t       addr;
    csr_data_t   val;
    page_t       pg;
    mem_addr_t   base;
    int          nbad;
    int          bad;
    logic [31:0] r;

    rng_state = 32'hc5fa_81b5;
    sys_clk = 1'b0;
    sys_rst = 1'b1;
    csr_a = '0;
    csr_we = 1'b0;
    csr_di = '0;
    load_we = 1'b0;
    load_addr = '0;
    load_data = '0;
    model_addr = '0;
    model_mode = MODE_SINGLE;
    model_irq_en = 1'b0;
    repeat (10) @(posedge sys_clk);
    #1;
    sys_rst = 1'b0;

    // Reset values
    check_irq(1'b0, "irq after reset");
    for (int ofs = 0; ofs < 8; ofs++) begin
      expect_csr(3'(ofs), '0, "CSR after reset");
    end

    // Idle readback
    model_addr = {next_rand(), next_rand()};
    r = next_rand();
    model_mode = checker_mode_t'(r[1:0]);
    model_irq_en = 1'b1;
    csr_write(CSR_ADDR_LO, model_addr[31:0]);
    csr_write(CSR_ADDR_HI, model_addr[63:32]);
    csr_write(CSR_CTRL, ctrl_value(1'b0));
    expect_csr(CSR_ADDR_LO, model_addr[31:0], "ADDR_LO readback");
    expect_csr(CSR_ADDR_HI, model_addr[63:32], "ADDR_HI readback");
    expect_csr(CSR_CTRL, ctrl_value(1'b0), "CTRL readback");
    // Outside the window reads 0
    csr_read({4'h5, 7'd0, CSR_CTRL}, val);
    check_csr(val, '0, "unselected window");
    check_irq(1'b0, "irq with no events");

    fill_good_memory();

    // Dummy, then clear done through STAT
    run_mode(MODE_DUMMY, {next_rand(), next_rand()}, 1'b0, 1'b0, '0);
    check_irq(1'b1, "irq after dummy");
    csr_write(CSR_STAT, 32'h1);
    check_irq(1'b0, "irq after done clear");
    expect_csr(CSR_STAT, '0, "STAT after done clear");

    // Read fetches one quad word, upper address bits ignored
    for (int i = 0; i < 4; i++) begin
      addr = {next_rand(), next_rand()};
      run_mode(MODE_READ, addr, 1'b0, 1'b1, mem_model[addr[7:0]]);
    end

    // Single page scans, every other one corrupted
    for (int i = 0; i < 8; i++) begin
      r = next_rand();
      pg = r[3:0];
      base = {pg, 4'h0};
      for (int j = 0; j < 16; j++) begin
        load_word(mem_addr_t'(base + j), good_word(next_rand()));
      end
      nbad = (i % 2 == 0) ? 0 : 1 + (next_rand() % 3);
      for (int k = 0; k < nbad; k++) begin
        r = next_rand();
        load_word({pg, r[3:0]}, mem_model[{pg, r[3:0]}] ^ (64'd1 << (next_rand() % 64)));
      end
      bad = first_bad_addr(int'(base), int'(base) + 15);
      addr = {next_rand(), next_rand()};
      addr[7:4] = pg;
      run_mode(MODE_SINGLE, addr, bad >= 0, bad >= 0, word_t'(mem_addr_t'(bad)));
    end

    // Auto over the whole memory with scattered corruption
    fill_good_memory();
    nbad = 1 + (next_rand() % 3);
    for (int k = 0; k < nbad; k++) begin
      r = next_rand();
      load_word(r[7:0], mem_model[r[7:0]] ^ (64'd1 << (next_rand() % 64)));
    end
    bad = first_bad_addr(0, MEM_DEPTH - 1);
    run_mode(MODE_AUTO, {next_rand(), next_rand()}, bad >= 0, bad >= 0, word_t'(mem_addr_t'(bad)));
    fill_good_memory();
    run_mode(MODE_AUTO, {next_rand(), next_rand()}, 1'b0, 1'b0, '0);

    // Writes during a run, then abort
    csr_write(CSR_STAT, 32'h3);
    model_mode = MODE_AUTO;
    model_irq_en = 1'b1;
    csr_write(CSR_CTRL, ctrl_value(1'b1));
    csr_write(CSR_ADDR_LO, ~model_addr[31:0]);
    csr_write(CSR_ADDR_HI, ~model_addr[63:32]);
    // Only start is taken while busy
    csr_write(CSR_CTRL, {28'd0, 1'b1, MODE_READ, 1'b0});
    expect_csr(CSR_CTRL, ctrl_value(1'b1), "CTRL during run");
    csr_write(CSR_CTRL, ctrl_value(1'b0));
    expect_csr(CSR_CTRL, ctrl_value(1'b0), "CTRL after abort");
    expect_csr(CSR_ADDR_LO, model_addr[31:0], "ADDR_LO after busy write");
    expect_csr(CSR_ADDR_HI, model_addr[63:32], "ADDR_HI after busy write");
    expect_no_irq(600);
    expect_csr(CSR_STAT, '0, "STAT after abort");

    // Engine back in idle and usable
    run_mode(MODE_DUMMY, model_addr, 1'b0, 1'b0, '0);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* checker.f */
checker_pkg.sv
checker_mem_if.sv
checker_ctlif.sv
checker_engine.sv
checker_mem.sv
checker_top.sv
tb_checker.sv
